/* sim.f */
+incdir+rtl
rtl/mci_pkg.sv
rtl/mci_reg_pkg.sv
rtl/mci_ctrl_ifs.sv
rtl/mci_reg_block.sv
rtl/mci_boot_seqr.sv
rtl/mci_wdt.sv
rtl/mci_top.sv
testbench/mci_properties.sv
testbench/tb_mci_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mci_top -o tb_mci_top \
    && ./obj_dir/tb_mci_top > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* testbench/tb_mci_top.sv */
// Management controller testbench
// Directed tests of boot, breakpoint, registers, MCU reset, watchdog and errors

`timescale 1ns/1ps
`include "mci_consts.svh"

module tb_mci_top
    import mci_pkg::*, mci_reg_pkg::*;
();

    // Tests take roughly 300 cycles, limit leaves a wide margin
    localparam int MAX_CYCLES = 3000;

    logic                   clk;
    logic                   rst_n_i;
    logic                   req_dv_i;
    logic                   req_write_i;
    logic [`MCI_ADDR_W-1:0] req_addr_i;
    logic [`MCI_DATA_W-1:0] req_wdata_i;
    logic [`MCI_DATA_W-1:0] rsp_rdata_o;
    logic                   rsp_error_o;
    logic                   lc_done_i;
    logic                   lc_init_o;
    logic                   fc_opt_done_i;
    logic                   fc_opt_init_o;
    logic                   boot_brkpoint_i;
    logic                   mcu_rst_b_o;
    logic                   cptra_rst_b_o;
    logic [`MCI_DATA_W-1:0] agg_error_fatal_i;
    logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i;
    logic                   all_error_fatal_o;
    logic                   all_error_non_fatal_o;
    logic [`MCI_DATA_W-1:0] generic_input_i;
    logic [`MCI_DATA_W-1:0] generic_output_o;
    logic [`MCI_DATA_W-1:0] strap_mcu_reset_vector_i;
    logic [`MCI_DATA_W-1:0] mcu_reset_vector_o;
    logic                   mci_intr_o;
    logic                   nmi_intr_o;

    int                     errors = 0;
    int                     cycles = 0;
    logic [`MCI_DATA_W-1:0] rdata;
    logic                   rerr;

    mci_top dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles, tests did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////
    // Drive helpers
    ////////////////////
    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (3) step();
        rst_n_i = 1'b1;
    endtask

    task automatic bus_write(input logic [`MCI_ADDR_W-1:0] addr,
                             input logic [`MCI_DATA_W-1:0] data);
        req_dv_i    = 1'b1;
        req_write_i = 1'b1;
        req_addr_i  = addr;
        req_wdata_i = data;
        step();
        req_dv_i    = 1'b0;
        req_write_i = 1'b0;
    endtask

    // Read data and error flag land one cycle after the access
    task automatic bus_read(input logic [`MCI_ADDR_W-1:0] addr,
                            output logic [`MCI_DATA_W-1:0] data, output logic err);
        req_dv_i    = 1'b1;
        req_write_i = 1'b0;
        req_addr_i  = addr;
        step();
        req_dv_i    = 1'b0;
        data        = rsp_rdata_o;
        err         = rsp_error_o;
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_word(input string name, input logic [`MCI_DATA_W-1:0] exp,
                              input logic [`MCI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input mci_boot_state_e exp,
                               input mci_boot_state_e act);
        if (act !== exp) begin
            $display("FAIL %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
            errors++;
        end
    endtask

    function automatic logic error_out(input logic fatal);
        return fatal ? all_error_fatal_o : all_error_non_fatal_o;
    endfunction

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic normal_boot();
        int n;
        check_bit("boot reset lc_init", 1'b0, lc_init_o);
        check_bit("boot reset mcu_rst_b", 1'b0, mcu_rst_b_o);
        check_bit("boot reset cptra_rst_b", 1'b0, cptra_rst_b_o);
        check_bit("boot reset rsp_error", 1'b0, rsp_error_o);
        check_bit("boot reset interrupts", 1'b0, mci_intr_o | nmi_intr_o);
        check_bit("boot reset errors", 1'b0, all_error_fatal_o | all_error_non_fatal_o);
        step();
        check_bit("boot lc_init", 1'b1, lc_init_o);
        lc_done_i = 1'b1;
        for (n = 0; n < 10 && !fc_opt_init_o; n++) begin
            step();
        end
        lc_done_i = 1'b0;
        check_bit("boot fc_opt_init", 1'b1, fc_opt_init_o);
        fc_opt_done_i = 1'b1;
        for (n = 0; n < 10 && !mcu_rst_b_o; n++) begin
            step();
        end
        fc_opt_done_i = 1'b0;
        check_bit("boot mcu_rst_b", 1'b1, mcu_rst_b_o);
        repeat (5) step();
        check_bit("boot cptra held", 1'b0, cptra_rst_b_o);
        bus_write(CPTRA_BOOT_GO, $urandom);
        for (n = 0; n < 5 && !cptra_rst_b_o; n++) begin
            step();
        end
        check_bit("boot cptra_rst_b", 1'b1, cptra_rst_b_o);
        bus_read(BOOT_STATUS, rdata, rerr);
        check_state("boot status", BOOT_DONE, mci_boot_state_e'(rdata[2:0]));
    endtask

    task automatic breakpoint();
        logic rose;
        int   n;
        boot_brkpoint_i = 1'b1;
        apply_reset();
        lc_done_i     = 1'b1;
        fc_opt_done_i = 1'b1;
        rose          = 1'b0;
        repeat (50) begin
            step();
            rose = rose | mcu_rst_b_o;
        end
        lc_done_i     = 1'b0;
        fc_opt_done_i = 1'b0;
        check_bit("brk mcu held", 1'b0, rose);
        bus_read(BOOT_STATUS, rdata, rerr);
        check_state("brk status", BOOT_BRKPOINT, mci_boot_state_e'(rdata[2:0]));
        bus_write(BOOTFSM_GO, $urandom);
        for (n = 0; n < 5 && !mcu_rst_b_o; n++) begin
            step();
        end
        check_bit("brk released", 1'b1, mcu_rst_b_o);
        boot_brkpoint_i = 1'b0;
    endtask

    task automatic registers();
        logic [`MCI_DATA_W-1:0] value;
        repeat (4) begin
            value = $urandom;
            bus_write(GENERIC_OUT, value);
            check_word("regs generic_out port", value, generic_output_o);
            bus_read(GENERIC_OUT, rdata, rerr);
            check_word("regs generic_out read", value, rdata);
        end
        generic_input_i = $urandom;
        bus_read(GENERIC_IN, rdata, rerr);
        check_word("regs generic_in", generic_input_i, rdata);
        bus_read(RESET_VECTOR, rdata, rerr);
        check_word("regs reset vector strap", strap_mcu_reset_vector_i, rdata);
        value = $urandom;
        bus_write(RESET_VECTOR, value);
        check_word("regs reset vector port", value, mcu_reset_vector_o);
        bus_read(8'hFC, rdata, rerr);
        check_bit("regs unmapped error", 1'b1, rerr);
        check_word("regs unmapped data", '0, rdata);
        step();
        check_bit("regs error clears", 1'b0, rsp_error_o);
    endtask

    task automatic mcu_reset();
        int n;
        bus_write(RESET_REQUEST, $urandom);
        for (n = 0; n < 5 && mcu_rst_b_o; n++) begin
            step();
        end
        check_bit("mcu_reset entered", 1'b0, mcu_rst_b_o);
        // Count the cycles spent in reset
        for (n = 0; n < 40 && !mcu_rst_b_o; n++) begin
            step();
        end
        check_word("mcu_reset low cycles", 32'd16, n);
        bus_read(BOOT_STATUS, rdata, rerr);
        check_bit("mcu_reset once flag", 1'b1, rdata[8]);
        check_state("mcu_reset status", BOOT_DONE, mci_boot_state_e'(rdata[2:0]));
    endtask

    task automatic watchdog();
        int n;
        bus_write(WDT_T1_PERIOD, 32'd20);
        bus_write(WDT_T2_PERIOD, 32'd30);
        bus_write(WDT_T2_EN, 32'd1);
        bus_write(WDT_T1_EN, 32'd1);
        for (n = 0; n < 25 && !mci_intr_o; n++) begin
            step();
        end
        check_bit("wdt t1 timeout", 1'b1, mci_intr_o);
        bus_write(WDT_STATUS, 32'h1);
        check_bit("wdt t1 serviced", 1'b0, mci_intr_o);
        check_bit("wdt no early nmi", 1'b0, nmi_intr_o);
        // No service this time, timer 2 must expire
        for (n = 0; n < 80 && !nmi_intr_o; n++) begin
            step();
        end
        check_bit("wdt nmi", 1'b1, nmi_intr_o);
        bus_write(WDT_T1_EN, 32'd0);
        bus_write(WDT_T2_EN, 32'd0);
        bus_write(WDT_STATUS, 32'h3);
        check_bit("wdt nmi sticky", 1'b1, nmi_intr_o);
        check_bit("wdt intr cleared", 1'b0, mci_intr_o);
        bus_read(WDT_STATUS, rdata, rerr);
        check_word("wdt status", 32'h2, rdata);
    endtask

    task automatic error_path(input logic fatal);
        string                  tname;
        mci_err_regs_t          model;
        mci_reg_addr_e          stat_addr;
        mci_reg_addr_e          mask_addr;
        logic [`MCI_DATA_W-1:0] bits;
        logic [`MCI_DATA_W-1:0] w1c;
        if (fatal) begin
            tname     = "err fatal";
            stat_addr = ERR_FATAL;
            mask_addr = ERR_FATAL_MASK;
        end else begin
            tname     = "err non_fatal";
            stat_addr = ERR_NON_FATAL;
            mask_addr = ERR_NON_FATAL_MASK;
        end
        model = '0;
        bits  = $urandom | 32'h1;
        if (fatal) begin
            agg_error_fatal_i = bits;
        end else begin
            agg_error_non_fatal_i = bits;
        end
        step();
        agg_error_fatal_i     = '0;
        agg_error_non_fatal_i = '0;
        model.status = model.status | bits;
        bus_read(stat_addr, rdata, rerr);
        check_word({tname, " status"}, model.status, rdata);
        // Bit 0 is always set and nothing is masked yet
        check_bit({tname, " raised"}, 1'b1, error_out(fatal));
        // Mask every set bit
        model.mask = model.status;
        bus_write(mask_addr, model.mask);
        check_bit({tname, " masked"}, 1'b0, error_out(fatal));
        bus_read(mask_addr, rdata, rerr);
        check_word({tname, " mask"}, model.mask, rdata);
        w1c = model.status;
        bus_write(stat_addr, w1c);
        model.status = model.status & ~w1c;
        bus_read(stat_addr, rdata, rerr);
        check_word({tname, " cleared"}, model.status, rdata);
        model.mask = '0;
        bus_write(mask_addr, model.mask);
        check_bit({tname, " unmasked"}, 1'b0, error_out(fatal));
    endtask

    initial begin
        clk                      = 1'b0;
        rst_n_i                  = 1'b0;
        req_dv_i                 = 1'b0;
        req_write_i              = 1'b0;
        req_addr_i               = '0;
        req_wdata_i              = '0;
        lc_done_i                = 1'b0;
        fc_opt_done_i            = 1'b0;
        boot_brkpoint_i          = 1'b0;
        agg_error_fatal_i        = '0;
        agg_error_non_fatal_i    = '0;
        generic_input_i          = '0;
        void'($urandom(32'h7f2177bd));
        strap_mcu_reset_vector_i = $urandom;
        apply_reset();
        normal_boot();
        breakpoint();
        registers();
        mcu_reset();
        watchdog();
        error_path(1'b1);
        error_path(1'b0);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* testbench/mci_properties.sv */
// Management controller assertions
// Init handshake, bus error, NMI and reset rules on the top level

`timescale 1ns/1ps

module mci_properties (
    input logic clk,
    input logic rst_n_i,
    input logic req_dv_i,
    input logic rsp_error_o,
    input logic lc_done_i,
    input logic lc_init_o,
    input logic fc_opt_init_o,
    input logic mcu_rst_b_o,
    input logic cptra_rst_b_o,
    input logic nmi_intr_o
);

    // Fuse init starts only after the lifecycle handshake completed
    init_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(fc_opt_init_o) |-> $past(lc_init_o && lc_done_i))
        else $error("fc_opt_init_o rose without a completed lifecycle handshake");

    nmi_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        nmi_intr_o |=> nmi_intr_o)
        else $error("nmi_intr_o dropped without reset");

    error_after_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_error_o |-> $past(req_dv_i))
        else $error("rsp_error_o high without a preceding access");

    // Synchronous reset, outputs low from the next cycle
    resets_held: assert property (@(posedge clk)
        !rst_n_i |=> (!mcu_rst_b_o && !cptra_rst_b_o))
        else $error("MCU or Caliptra reset released during reset");

endmodule

bind mci_top mci_properties u_properties (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_dv_i      (req_dv_i),
    .rsp_error_o   (rsp_error_o),
    .lc_done_i     (lc_done_i),
    .lc_init_o     (lc_init_o),
    .fc_opt_init_o (fc_opt_init_o),
    .mcu_rst_b_o   (mcu_rst_b_o),
    .cptra_rst_b_o (cptra_rst_b_o),
    .nmi_intr_o    (nmi_intr_o)
);

/* rtl/mci_top.sv */
// Management controller top level
// Register bank, boot sequencer and watchdog joined by the control interfaces

`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // Register bus
    input  logic                   req_dv_i,
    input  logic                   req_write_i,
    input  logic [`MCI_ADDR_W-1:0] req_addr_i,
    input  logic [`MCI_DATA_W-1:0] req_wdata_i,
    output logic [`MCI_DATA_W-1:0] rsp_rdata_o,
    output logic                   rsp_error_o,

    // Boot handshakes and resets
    input  logic                   lc_done_i,
    output logic                   lc_init_o,
    input  logic                   fc_opt_done_i,
    output logic                   fc_opt_init_o,
    input  logic                   boot_brkpoint_i,
    output logic                   mcu_rst_b_o,
    output logic                   cptra_rst_b_o,

    // Errors
    input  logic [`MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,

    // Generic wires and reset vector
    input  logic [`MCI_DATA_W-1:0] generic_input_i,
    output logic [`MCI_DATA_W-1:0] generic_output_o,
    input  logic [`MCI_DATA_W-1:0] strap_mcu_reset_vector_i,
    output logic [`MCI_DATA_W-1:0] mcu_reset_vector_o,

    // MCU interrupts
    output logic                   mci_intr_o,
    output logic                   nmi_intr_o
);

    mci_boot_if boot_if ();
    mci_wdt_if  wdt_if ();

    // Port names match the top level, connect by name
    mci_reg_block u_reg_block (.*);

    mci_boot_seqr u_boot_seqr (.*);

    mci_wdt u_wdt (.*);

endmodule

/* rtl/mci_wdt.sv */
// Cascaded watchdog
// Timer 1 raises an interrupt, timer 2 runs on an unserviced timeout
// and raises the fatal timeout

`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_wdt
    import mci_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    mci_wdt_if.wdt_side  wdt_if
);

    mci_wdt_state_e         state_q;
    mci_wdt_state_e         state_d;
    logic [`MCI_DATA_W-1:0] t1_cnt_q;
    logic [`MCI_DATA_W-1:0] t2_cnt_q;
    logic                   t1_hit;
    logic                   t2_hit;

    assign t1_hit = (state_q == WDT_T1) && wdt_if.t1_en && (t1_cnt_q == wdt_if.t1_period);
    assign t2_hit = (state_q == WDT_T2) && wdt_if.t2_en && (t2_cnt_q == wdt_if.t2_period);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WDT_IDLE: begin
                if (wdt_if.t1_en) begin
                    state_d = WDT_T1;
                end
            end
            WDT_T1: begin
                if (!wdt_if.t1_en) begin
                    state_d = WDT_IDLE;
                end else if (t1_hit) begin
                    state_d = WDT_T2;
                end
            end
            WDT_T2: begin
                // Service of timer 1 rearms the first stage
                if (wdt_if.t1_serviced) begin
                    state_d = WDT_T1;
                end else if (t2_hit) begin
                    state_d = WDT_FATAL;
                end
            end
            default: begin
                if (wdt_if.t2_serviced) begin
                    state_d = WDT_IDLE;
                end
            end
        endcase
    end

    // Counters only advance while staying in their own stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= WDT_IDLE;
            t1_cnt_q <= '0;
            t2_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == WDT_T1) && (state_d == WDT_T1) && !wdt_if.t1_restart) begin
                t1_cnt_q <= t1_cnt_q + 1'b1;
            end else begin
                t1_cnt_q <= '0;
            end
            if ((state_q == WDT_T2) && (state_d == WDT_T2) && wdt_if.t2_en
                && !wdt_if.t2_restart) begin
                t2_cnt_q <= t2_cnt_q + 1'b1;
            end else begin
                t2_cnt_q <= '0;
            end
        end
    end

    assign wdt_if.t1_timeout_p = t1_hit;
    assign wdt_if.t2_timeout_p = t2_hit;

endmodule

/* rtl/mci_boot_seqr.sv */
// Boot sequencer
// Walks lifecycle and fuse init, an optional breakpoint, then releases
// the MCU and Caliptra resets; also runs requested MCU resets

`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_boot_seqr
    import mci_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           lc_done_i,
    output logic           lc_init_o,
    input  logic           fc_opt_done_i,
    output logic           fc_opt_init_o,
    input  logic           boot_brkpoint_i,
    output logic           mcu_rst_b_o,
    output logic           cptra_rst_b_o,
    mci_boot_if.seqr_side  boot_if
);

    mci_boot_state_e           state_q;
    mci_boot_state_e           state_d;
    logic [`MCI_RST_CNT_W-1:0] rst_cnt_q;

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE: begin
                state_d = BOOT_LCC;
            end
            BOOT_LCC: begin
                if (lc_done_i) begin
                    state_d = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                if (fc_opt_done_i) begin
                    state_d = boot_brkpoint_i ? BOOT_BRKPOINT : BOOT_DONE;
                end
            end
            BOOT_BRKPOINT: begin
                if (boot_if.bootfsm_go) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_DONE: begin
                if (boot_if.mcu_rst_req) begin
                    state_d = BOOT_MCU_RST;
                end
            end
            BOOT_MCU_RST: begin
                // Leave once the counter is about to wrap
                if (&rst_cnt_q) begin
                    state_d = BOOT_DONE;
                end
            end
            default: begin
                state_d = BOOT_IDLE;
            end
        endcase
    end

    ////////////////////
    // State and reset outputs
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q                <= BOOT_IDLE;
            rst_cnt_q              <= '0;
            mcu_rst_b_o            <= 1'b0;
            cptra_rst_b_o          <= 1'b0;
            boot_if.mcu_reset_once <= 1'b0;
        end else begin
            state_q     <= state_d;
            rst_cnt_q   <= (state_q == BOOT_MCU_RST) ? rst_cnt_q + 1'b1 : '0;
            mcu_rst_b_o <= (state_q == BOOT_DONE);
            // Caliptra stays out of reset once released
            if ((state_q == BOOT_DONE) && boot_if.cptra_boot_go) begin
                cptra_rst_b_o <= 1'b1;
            end
            if ((state_q == BOOT_MCU_RST) && (state_d == BOOT_DONE)) begin
                boot_if.mcu_reset_once <= 1'b1;
            end
        end
    end

    // Init requests follow the state directly
    assign lc_init_o     = (state_q == BOOT_LCC);
    assign fc_opt_init_o = (state_q == BOOT_FUSE);
    assign boot_if.state = state_q;

endmodule

/* rtl/mci_reg_block.sv */
// Management controller register bank
// Decodes the register bus, keeps sticky error and watchdog status
// and turns writes into control pulses

`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_reg_block
    import mci_reg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_dv_i,
    input  logic                   req_write_i,
    input  logic [`MCI_ADDR_W-1:0] req_addr_i,
    input  logic [`MCI_DATA_W-1:0] req_wdata_i,
    output logic [`MCI_DATA_W-1:0] rsp_rdata_o,
    output logic                   rsp_error_o,
    input  logic [`MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    input  logic [`MCI_DATA_W-1:0] generic_input_i,
    output logic [`MCI_DATA_W-1:0] generic_output_o,
    input  logic [`MCI_DATA_W-1:0] strap_mcu_reset_vector_i,
    output logic [`MCI_DATA_W-1:0] mcu_reset_vector_o,
    output logic                   mci_intr_o,
    output logic                   nmi_intr_o,
    mci_boot_if.reg_side           boot_if,
    mci_wdt_if.reg_side            wdt_if
);

    mci_reg_addr_e          addr;
    logic                   addr_hit;
    logic                   wr_en;
    logic [`MCI_DATA_W-1:0] rd_data;
    logic [1:0]             wdt_status_q;
    mci_err_regs_t          err_fatal_q;
    mci_err_regs_t          err_non_fatal_q;

    // W1C on status, plain write on mask, new errors always win
    function automatic mci_err_regs_t err_next(
        input mci_err_regs_t          cur,
        input logic [`MCI_DATA_W-1:0] agg,
        input logic                   wr_status,
        input logic                   wr_mask,
        input logic [`MCI_DATA_W-1:0] wdata
    );
        mci_err_regs_t nxt;
        nxt = cur;
        if (wr_status) begin
            nxt.status = nxt.status & ~wdata;
        end
        if (wr_mask) begin
            nxt.mask = wdata;
        end
        nxt.status = nxt.status | agg;
        return nxt;
    endfunction

    ////////////////////
    // Decode and read mux
    ////////////////////
    assign addr  = mci_reg_addr_e'(req_addr_i);
    assign wr_en = req_dv_i && req_write_i && addr_hit;

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (addr)
            BOOT_STATUS: begin
                rd_data[2:0] = boot_if.state;
                rd_data[8]   = boot_if.mcu_reset_once;
            end
            WDT_T1_EN:          rd_data[0]   = wdt_if.t1_en;
            WDT_T1_PERIOD:      rd_data      = wdt_if.t1_period;
            WDT_T2_EN:          rd_data[0]   = wdt_if.t2_en;
            WDT_T2_PERIOD:      rd_data      = wdt_if.t2_period;
            WDT_STATUS:         rd_data[1:0] = wdt_status_q;
            ERR_FATAL:          rd_data      = err_fatal_q.status;
            ERR_FATAL_MASK:     rd_data      = err_fatal_q.mask;
            ERR_NON_FATAL:      rd_data      = err_non_fatal_q.status;
            ERR_NON_FATAL_MASK: rd_data      = err_non_fatal_q.mask;
            GENERIC_IN:         rd_data      = generic_input_i;
            GENERIC_OUT:        rd_data      = generic_output_o;
            RESET_VECTOR:       rd_data      = mcu_reset_vector_o;
            // Pulse registers read as zero
            BOOTFSM_GO, CPTRA_BOOT_GO, RESET_REQUEST, WDT_T1_CTRL, WDT_T2_CTRL: begin
                rd_data = '0;
            end
            default:            addr_hit     = 1'b0;
        endcase
    end

    ////////////////////
    // Register state
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            boot_if.bootfsm_go    <= 1'b0;
            boot_if.cptra_boot_go <= 1'b0;
            boot_if.mcu_rst_req   <= 1'b0;
            wdt_if.t1_en          <= 1'b0;
            wdt_if.t2_en          <= 1'b0;
            wdt_if.t1_restart     <= 1'b0;
            wdt_if.t2_restart     <= 1'b0;
            wdt_if.t1_period      <= `MCI_WDT_PERIOD_DEFAULT;
            wdt_if.t2_period      <= `MCI_WDT_PERIOD_DEFAULT;
            wdt_if.t1_serviced    <= 1'b0;
            wdt_if.t2_serviced    <= 1'b0;
            wdt_status_q          <= 2'b00;
            err_fatal_q           <= '0;
            err_non_fatal_q       <= '0;
            generic_output_o      <= '0;
            mcu_reset_vector_o    <= strap_mcu_reset_vector_i;
            rsp_error_o           <= 1'b0;
        end else begin
            // One-cycle pulses, any written value triggers
            boot_if.bootfsm_go    <= wr_en && (addr == BOOTFSM_GO);
            boot_if.cptra_boot_go <= wr_en && (addr == CPTRA_BOOT_GO);
            boot_if.mcu_rst_req   <= wr_en && (addr == RESET_REQUEST);
            wdt_if.t1_restart     <= wr_en && (addr == WDT_T1_CTRL);
            wdt_if.t2_restart     <= wr_en && (addr == WDT_T2_CTRL);
            wdt_if.t1_serviced    <= wr_en && (addr == WDT_STATUS) && req_wdata_i[0];
            wdt_if.t2_serviced    <= wr_en && (addr == WDT_STATUS) && req_wdata_i[1];

            if (wr_en) begin
                case (addr)
                    WDT_T1_EN:     wdt_if.t1_en       <= req_wdata_i[0];
                    WDT_T1_PERIOD: wdt_if.t1_period   <= req_wdata_i;
                    WDT_T2_EN:     wdt_if.t2_en       <= req_wdata_i[0];
                    WDT_T2_PERIOD: wdt_if.t2_period   <= req_wdata_i;
                    GENERIC_OUT:   generic_output_o   <= req_wdata_i;
                    RESET_VECTOR:  mcu_reset_vector_o <= req_wdata_i;
                    default:       ;
                endcase
            end

            // T1 timeout is W1C, the NMI bit holds until reset
            wdt_status_q[0] <= (wdt_status_q[0]
                                && !(wr_en && (addr == WDT_STATUS) && req_wdata_i[0]))
                               || wdt_if.t1_timeout_p;
            wdt_status_q[1] <= wdt_status_q[1] || wdt_if.t2_timeout_p;

            err_fatal_q <= err_next(err_fatal_q, agg_error_fatal_i,
                                    wr_en && (addr == ERR_FATAL),
                                    wr_en && (addr == ERR_FATAL_MASK), req_wdata_i);
            err_non_fatal_q <= err_next(err_non_fatal_q, agg_error_non_fatal_i,
                                        wr_en && (addr == ERR_NON_FATAL),
                                        wr_en && (addr == ERR_NON_FATAL_MASK), req_wdata_i);

            rsp_error_o <= req_dv_i && !addr_hit;
        end
    end

    // Read data lands one cycle after the access
    always_ff @(posedge clk) begin
        if (req_dv_i && !req_write_i) begin
            rsp_rdata_o <= rd_data;
        end
    end

    ////////////////////
    // Interrupts
    ////////////////////
    assign all_error_fatal_o     = |(err_fatal_q.status & ~err_fatal_q.mask);
    assign all_error_non_fatal_o = |(err_non_fatal_q.status & ~err_non_fatal_q.mask);
    assign mci_intr_o            = wdt_status_q[0];
    assign nmi_intr_o            = wdt_status_q[1];

endmodule

/* rtl/mci_ctrl_ifs.sv */
// Management controller control interfaces
// Boot control and watchdog control between the register bank and the engines

`timescale 1ns/1ps
`include "mci_consts.svh"

// Boot pulses down, sequencer state up
interface mci_boot_if
    import mci_pkg::*;
();
    logic            bootfsm_go;
    logic            cptra_boot_go;
    logic            mcu_rst_req;
    mci_boot_state_e state;
    logic            mcu_reset_once;

    modport reg_side (
        output bootfsm_go, cptra_boot_go, mcu_rst_req,
        input  state, mcu_reset_once
    );

    modport seqr_side (
        input  bootfsm_go, cptra_boot_go, mcu_rst_req,
        output state, mcu_reset_once
    );
endinterface

// Timer controls down, timeout pulses up
interface mci_wdt_if ();
    logic                   t1_en;
    logic                   t2_en;
    logic                   t1_restart;
    logic                   t2_restart;
    logic [`MCI_DATA_W-1:0] t1_period;
    logic [`MCI_DATA_W-1:0] t2_period;
    logic                   t1_serviced;
    logic                   t2_serviced;
    logic                   t1_timeout_p;
    logic                   t2_timeout_p;

    modport reg_side (
        output t1_en, t2_en, t1_restart, t2_restart, t1_period, t2_period,
        output t1_serviced, t2_serviced,
        input  t1_timeout_p, t2_timeout_p
    );

    modport wdt_side (
        input  t1_en, t2_en, t1_restart, t2_restart, t1_period, t2_period,
        input  t1_serviced, t2_serviced,
        output t1_timeout_p, t2_timeout_p
    );
endinterface

/* rtl/mci_reg_pkg.sv */
// Management controller register map package
// Register offsets and the error status type

`include "mci_consts.svh"

package mci_reg_pkg;

    // Byte offsets, also the bus opcodes
    typedef enum logic [`MCI_ADDR_W-1:0] {
        BOOTFSM_GO         = 8'h00,
        CPTRA_BOOT_GO      = 8'h04,
        RESET_REQUEST      = 8'h08,
        BOOT_STATUS        = 8'h0C,
        WDT_T1_EN          = 8'h10,
        WDT_T1_CTRL        = 8'h14,
        WDT_T1_PERIOD      = 8'h18,
        WDT_T2_EN          = 8'h1C,
        WDT_T2_CTRL        = 8'h20,
        WDT_T2_PERIOD      = 8'h24,
        WDT_STATUS         = 8'h28,
        ERR_FATAL          = 8'h2C,
        ERR_FATAL_MASK     = 8'h30,
        ERR_NON_FATAL      = 8'h34,
        ERR_NON_FATAL_MASK = 8'h38,
        GENERIC_IN         = 8'h3C,
        GENERIC_OUT        = 8'h40,
        RESET_VECTOR       = 8'h44
    } mci_reg_addr_e;

    // Sticky error word with its mask, a set mask bit hides the error
    typedef struct packed {
        logic [`MCI_DATA_W-1:0] status;
        logic [`MCI_DATA_W-1:0] mask;
    } mci_err_regs_t;

endpackage

/* rtl/mci_pkg.sv */
// Management controller control package
// State encodings of the boot sequencer and the watchdog

`include "mci_consts.svh"

package mci_pkg;

    ////////////////////
    // Boot sequencer
    ////////////////////
    typedef enum logic [`MCI_BOOT_ST_W-1:0] {
        BOOT_IDLE     = 3'd0,
        BOOT_LCC      = 3'd1,
        BOOT_FUSE     = 3'd2,
        BOOT_BRKPOINT = 3'd3,
        BOOT_MCU_RST  = 3'd4,
        BOOT_DONE     = 3'd5
    } mci_boot_state_e;

    ////////////////////
    // Watchdog
    ////////////////////
    // T2 only runs after an unserviced T1 timeout
    typedef enum logic [`MCI_WDT_ST_W-1:0] {
        WDT_IDLE  = 2'd0,
        WDT_T1    = 2'd1,
        WDT_T2    = 2'd2,
        WDT_FATAL = 2'd3
    } mci_wdt_state_e;

endpackage

/* rtl/mci_consts.svh */
// Management controller constants
// Widths, counts and reset values shared by the design

`ifndef MCI_CONSTS_SVH
`define MCI_CONSTS_SVH

// Bus and register widths
`define MCI_DATA_W 32
`define MCI_ADDR_W 8

// State encoding widths
`define MCI_BOOT_ST_W 3
`define MCI_WDT_ST_W 2

// MCU reset hold counter, wraps after 16 cycles
`define MCI_RST_CNT_W 4

// Watchdog periods out of reset
`define MCI_WDT_PERIOD_DEFAULT 32'hFFFF_FFFF

`endif
